/* bench/wmem_asserts.sv */
`timescale 1ns/1ps

module wmem_asserts #(
  parameter int unsigned NB_BANKS = 8
) (
  input logic                     clk_b_i,
  input logic                     rst_ni,
  input wmem_pkg::wmem_axil_req_t axil_req_i,
  input wmem_pkg::wmem_axil_rsp_t axil_rsp_i,
  input wmem_pkg::wmem_rd_req_t   rd_req_i [NB_BANKS],
  input wmem_pkg::wmem_rd_rsp_t   rd_rsp_i [NB_BANKS]
);

  // b channel stays up until the master takes it
  a_bvalid_hold : assert property (@(posedge clk_b_i) disable iff (!rst_ni)
    axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid)
    else $error("bvalid dropped before bready was seen");

  // no new write while a response is pending
  a_no_aw_in_resp : assert property (@(posedge clk_b_i) disable iff (!rst_ni)
    axil_rsp_i.bvalid |-> !axil_rsp_i.awready)
    else $error("awready high while bvalid is high");

  // fixed one cycle read latency per bank
  for (genvar i = 0; i < NB_BANKS; i++)
  begin : g_rd
    a_rvalid_lat : assert property (@(posedge clk_b_i) disable iff (!rst_ni)
      rd_rsp_i[i].r_valid == $past(rd_req_i[i].req))
      else $error("r_valid does not follow req by one cycle");
  end

endmodule

bind wmem_top wmem_asserts #(
  .NB_BANKS (NB_BANKS)
) u_asserts (
  .clk_b_i    (clk_b_i),
  .rst_ni     (rst_ni),
  .axil_req_i (axil_req_i),
  .axil_rsp_i (axil_rsp_o),
  .rd_req_i   (rd_req_i),
  .rd_rsp_i   (rd_rsp_o)
);

/* bench/wmem_tb.sv */
`timescale 1ns/1ps

module wmem_tb;

  localparam int unsigned BANK_DEPTH = 16;
  localparam int unsigned NB_BANKS   = 8;
  localparam int unsigned NB_GROUPS  = NB_BANKS / 4;
  localparam int unsigned NB_WORDS   = BANK_DEPTH * NB_GROUPS;
  localparam int unsigned RST_CYCLES = 16;
  localparam int unsigned SEED       = 32'h209e_b8d2;

  // one table row
  // exp_resp is for writes and exp_rdata for reads
  typedef struct packed {
    logic                 is_wr;
    logic [31:0]          addr;
    logic [63:0]          data;
    logic [7:0]           strb;
    logic [7:0]           bdelay;
    wmem_pkg::wmem_resp_e exp_resp;
    logic [63:0]          exp_rdata;
  } step_t;

  logic                     clk;
  logic                     rst_n;
  wmem_pkg::wmem_axil_req_t axil_req;
  wmem_pkg::wmem_axil_rsp_t axil_rsp;
  wmem_pkg::wmem_rd_req_t   rd_req [NB_BANKS];
  wmem_pkg::wmem_rd_rsp_t   rd_rsp [NB_BANKS];

  step_t       steps [$];
  // bank level shadow updated while the table is built
  logic [15:0] shadow [NB_BANKS][BANK_DEPTH];
  int unsigned err_cnt = 0;
  int unsigned cyc_cnt = 0;
  int unsigned cyc_limit = 0;

  wmem_tb_clock #(
    .RST_CYCLES (RST_CYCLES)
  ) u_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  wmem_top #(
    .BANK_DEPTH (BANK_DEPTH),
    .NB_BANKS   (NB_BANKS)
  ) UUT (
    .clk_b_i    (clk),
    .rst_ni     (rst_n),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp),
    .rd_req_i   (rd_req),
    .rd_rsp_o   (rd_rsp)
  );

  // watchdog limit is set once the table length is known
  always @(posedge clk)
  begin
    cyc_cnt++;
    if (cyc_limit != 0 && cyc_cnt > cyc_limit)
    begin
      $display("timeout: the test did not finish within %0d cycles", cyc_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0d ns: %s, got %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // word w sits in group w % groups and row w / groups
  task automatic expect_write(input int unsigned word, input logic [63:0] data,
                              input logic [7:0] strb, input int unsigned bdelay);
    step_t       s;
    int unsigned grp;
    int unsigned row;
    s        = '0;
    s.is_wr  = 1'b1;
    s.addr   = 32'(word * 8);
    s.data   = data;
    s.strb   = strb;
    s.bdelay = 8'(bdelay);
    s.exp_resp = wmem_pkg::RESP_SLVERR;
    if (word < NB_WORDS)
    begin
      s.exp_resp = wmem_pkg::RESP_OKAY;
      grp = word % NB_GROUPS;
      row = word / NB_GROUPS;
      for (int j = 0; j < 4; j++)
      begin
        for (int k = 0; k < 2; k++)
        begin
          if (strb[2*j+k])
          begin
            shadow[4*grp+j][row][8*k +: 8] = data[16*j+8*k +: 8];
          end
        end
      end
    end
    steps.push_back(s);
  endtask

  task automatic expect_read(input int unsigned word);
    step_t       s;
    int unsigned grp;
    int unsigned row;
    s      = '0;
    s.addr = 32'(word * 8);
    grp    = word % NB_GROUPS;
    row    = word / NB_GROUPS;
    // lane j of the word comes from bank 4*group+j
    for (int j = 0; j < 4; j++)
    begin
      s.exp_rdata[16*j +: 16] = shadow[4*grp+j][row];
    end
    steps.push_back(s);
  endtask

  task automatic build_table();
    // lane split on word 0
    expect_write(0, {$urandom, $urandom}, 8'hff, 0);
    expect_read(0);
    // fill the rest so consecutive words alternate groups
    for (int unsigned w = 1; w < NB_WORDS; w++)
    begin
      expect_write(w, {$urandom, $urandom}, 8'hff, 0);
    end
    for (int unsigned w = 1; w < 5; w++)
    begin
      expect_read(w);
    end
    expect_read(NB_WORDS - 1);
    // partial strobes keep the other bytes
    expect_write(5, {$urandom, $urandom}, 8'h5a, 0);
    expect_read(5);
    expect_write(6, {$urandom, $urandom}, 8'h81, 0);
    expect_read(6);
    // out of range writes alias the rows of words 0 and 1
    expect_write(NB_WORDS, {$urandom, $urandom}, 8'hff, 0);
    expect_write(NB_WORDS + 1, {$urandom, $urandom}, 8'hff, 0);
    expect_read(0);
    expect_read(1);
    // bready held off while the next write waits behind it
    expect_write(9, {$urandom, $urandom}, 8'hff, 6);
    expect_write(10, {$urandom, $urandom}, 8'hff, 0);
    expect_read(9);
    expect_read(10);
  endtask

  task automatic verify_reset_outputs(input string when);
    compare(64'(axil_rsp.awready), 64'd0, {"awready ", when});
    compare(64'(axil_rsp.wready), 64'd0, {"wready ", when});
    compare(64'(axil_rsp.bvalid), 64'd0, {"bvalid ", when});
    for (int b = 0; b < NB_BANKS; b++)
    begin
      compare(64'(rd_rsp[b].r_valid), 64'd0, {"r_valid ", when});
    end
  endtask

  // entered and left on a falling edge
  task automatic drive_write(input step_t s, input step_t nxt, input logic has_nxt);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = s.addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = s.data;
    axil_req.wstrb   = s.strb;
    axil_req.bready  = 1'b0;
    #1;
    while (!axil_rsp.awready)
    begin
      @(negedge clk);
      #1;
    end
    compare(64'(axil_rsp.wready), 64'd1, "wready together with awready");
    @(negedge clk);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    compare(64'(axil_rsp.bvalid), 64'd1, "bvalid one cycle after handshake");
    compare(64'(axil_rsp.bresp), 64'(s.exp_resp), "bresp");
    // second write waits while b is stalled
    if (s.bdelay != 0 && has_nxt)
    begin
      axil_req.awvalid = 1'b1;
      axil_req.awaddr  = nxt.addr;
      axil_req.wvalid  = 1'b1;
      axil_req.wdata   = nxt.data;
      axil_req.wstrb   = nxt.strb;
    end
    repeat (s.bdelay)
    begin
      #1;
      compare(64'(axil_rsp.awready), 64'd0, "awready while response stalled");
      @(negedge clk);
      compare(64'(axil_rsp.bvalid), 64'd1, "bvalid held while bready low");
    end
    axil_req.bready = 1'b1;
    @(negedge clk);
    axil_req.bready = 1'b0;
    compare(64'(axil_rsp.bvalid), 64'd0, "bvalid after bready");
  endtask

  task automatic issue_read(input step_t s);
    int unsigned word;
    int unsigned grp;
    int unsigned row;
    logic [63:0] got;
    logic [63:0] held;
    word = s.addr >> 3;
    grp  = word % NB_GROUPS;
    row  = word / NB_GROUPS;
    // bit 0 is set but the bank ignores it
    for (int b = 0; b < NB_BANKS; b++)
    begin
      rd_req[b].req  = (b / 4 == grp);
      rd_req[b].addr = 16'((row << 1) | 1);
    end
    @(negedge clk);
    for (int b = 0; b < NB_BANKS; b++)
    begin
      rd_req[b].req = 1'b0;
      compare(64'(rd_rsp[b].r_valid), 64'(b / 4 == grp), "r_valid one cycle after req");
    end
    for (int j = 0; j < 4; j++)
    begin
      got[16*j +: 16] = rd_rsp[4*grp+j].rdata;
    end
    compare(got, s.exp_rdata, "read data");
    // idle cycle where data must hold
    @(negedge clk);
    for (int j = 0; j < 4; j++)
    begin
      held[16*j +: 16] = rd_rsp[4*grp+j].rdata;
      compare(64'(rd_rsp[4*grp+j].r_valid), 64'd0, "r_valid without req");
    end
    compare(held, got, "rdata held without req");
  endtask

  initial
  begin
    int unsigned errs_before;
    int unsigned n_bad;
    step_t       nxt;
    logic        has_nxt;
    void'($urandom(SEED));
    n_bad    = 0;
    axil_req = '0;
    for (int b = 0; b < NB_BANKS; b++)
    begin
      rd_req[b] = '0;
    end
    build_table();
    cyc_limit = 40 * steps.size() + RST_CYCLES;

    // reset state inside and just after reset
    repeat (RST_CYCLES / 2) @(negedge clk);
    verify_reset_outputs("during reset");
    @(posedge rst_n);
    @(negedge clk);
    verify_reset_outputs("after reset");
    if (err_cnt != 0)
    begin
      n_bad++;
    end
    $display("reset state: %s", (err_cnt == 0) ? "ok" : "mismatch");

    for (int i = 0; i < steps.size(); i++)
    begin
      errs_before = err_cnt;
      if (steps[i].is_wr)
      begin
        has_nxt = (i + 1 < steps.size()) && steps[i+1].is_wr;
        nxt     = '0;
        if (has_nxt)
        begin
          nxt = steps[i+1];
        end
        drive_write(steps[i], nxt, has_nxt);
      end
      else
      begin
        issue_read(steps[i]);
      end
      if (err_cnt != errs_before)
      begin
        n_bad++;
      end
      $display("step %0d %s addr %h: %s", i, steps[i].is_wr ? "write" : "read",
               steps[i].addr, (err_cnt == errs_before) ? "ok" : "mismatch");
    end

    $display("%0d tests, %0d with errors, %0d errors in total",
             steps.size() + 1, n_bad, err_cnt);
    if (err_cnt == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* bench/wmem_tb_clock.sv */
`timescale 1ns/1ps

module wmem_tb_clock #(
  parameter int unsigned RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  // 10 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial
  begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* rtl/wmem_axil_decode.sv */
`timescale 1ns/1ps

module wmem_axil_decode #(
  parameter int unsigned BANK_DEPTH = 256,
  parameter int unsigned NB_BANKS   = 8
) (
  input  logic                      clk_b_i,
  input  logic                      rst_ni,
  input  wmem_pkg::wmem_axil_req_t  axil_req_i,
  output wmem_pkg::wmem_axil_rsp_t  axil_rsp_o,
  output wmem_pkg::wmem_bank_wr_t   bank_wr_o [NB_BANKS]
);

  // shorthands for the package constants
  localparam int unsigned LANES  = wmem_pkg::WMEM_LANES;
  localparam int unsigned LANE_W = wmem_pkg::WMEM_LANE_W;
  localparam int unsigned BE_W   = LANE_W / 8;
  localparam int unsigned ROW_W  = wmem_pkg::WMEM_ROW_W;

  // word index drops the 3 byte-offset bits of a 64-bit word
  localparam int unsigned WORD_W    = wmem_pkg::WMEM_ADDR_W - 3;
  localparam int unsigned NB_GROUPS = NB_BANKS / LANES;

  localparam logic [WORD_W-1:0] GROUPS_W = WORD_W'(NB_GROUPS);
  localparam logic [WORD_W-1:0] NB_WORDS = WORD_W'(BANK_DEPTH * NB_GROUPS);

  wmem_pkg::wmem_dec_state_e state_q;
  wmem_pkg::wmem_resp_e      resp_q;

  logic [WORD_W-1:0] word_idx;
  logic [WORD_W-1:0] grp_idx;
  logic [WORD_W-1:0] row_idx;
  logic              in_range;
  logic              hs;
  logic              wr_fire;

  // word interleave across groups
  assign word_idx = axil_req_i.awaddr[wmem_pkg::WMEM_ADDR_W-1:3];
  assign grp_idx  = word_idx % GROUPS_W;
  assign row_idx  = word_idx / GROUPS_W;
  assign in_range = (word_idx < NB_WORDS);

  // aw and w are joined, both must be present while idle
  assign hs      = (state_q == wmem_pkg::ST_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
  assign wr_fire = hs && in_range;

  assign axil_rsp_o.awready = hs;
  assign axil_rsp_o.wready  = hs;
  // response straight from the registered state
  assign axil_rsp_o.bvalid  = (state_q == wmem_pkg::ST_RESP);
  assign axil_rsp_o.bresp   = resp_q;

  // lane split, bank 4*group+j takes lane j of the word
  always_comb
  begin
    for (int b = 0; b < NB_BANKS; b++)
    begin
      bank_wr_o[b].row   = row_idx[ROW_W-1:0];
      bank_wr_o[b].wdata = axil_req_i.wdata[LANE_W*(b%LANES) +: LANE_W];
      bank_wr_o[b].we    = '0;
      // only the selected group sees the strobes
      if (wr_fire && (grp_idx == WORD_W'(b / LANES)))
      begin
        bank_wr_o[b].we = axil_req_i.wstrb[BE_W*(b%LANES) +: BE_W];
      end
    end
  end

  // two state fsm, resp held until bready
  always_ff @(posedge clk_b_i)
  begin
    if (!rst_ni)
    begin
      state_q <= wmem_pkg::ST_IDLE;
    end
    else
    begin
      case (state_q)
        wmem_pkg::ST_IDLE:
        begin
          if (hs)
          begin
            state_q <= wmem_pkg::ST_RESP;
          end
        end
        wmem_pkg::ST_RESP:
        begin
          if (axil_req_i.bready)
          begin
            state_q <= wmem_pkg::ST_IDLE;
          end
        end
        default:
        begin
          state_q <= wmem_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // response code latched at the handshake
  always_ff @(posedge clk_b_i)
  begin
    if (hs)
    begin
      resp_q <= in_range ? wmem_pkg::RESP_OKAY : wmem_pkg::RESP_SLVERR;
    end
  end

endmodule

/* rtl/wmem_bank.sv */
`timescale 1ns/1ps

module wmem_bank #(
  parameter int unsigned BANK_DEPTH = 256
) (
  input  logic                                clk_b_i,
  input  wmem_pkg::wmem_bank_wr_t             wr_i,
  input  logic                                rd_en_i,
  input  logic [wmem_pkg::WMEM_ROW_W-1:0]     rd_row_i,
  output logic [wmem_pkg::WMEM_LANE_W-1:0]    rd_data_o
);

  localparam int unsigned LANE_W = wmem_pkg::WMEM_LANE_W;
  localparam int unsigned BE_W   = LANE_W / 8;
  // row bits actually decoded by the array
  localparam int unsigned ROW_AW = $clog2(BANK_DEPTH);

  // plain inferred array, no init
  logic [LANE_W-1:0] mem_q [BANK_DEPTH];
  logic [LANE_W-1:0] rd_data_q;

  logic [ROW_AW-1:0] wr_row;
  logic [ROW_AW-1:0] rd_row;

  assign wr_row = wr_i.row[ROW_AW-1:0];
  assign rd_row = rd_row_i[ROW_AW-1:0];

  // write and read share one process
  // nonblocking read picks up the old word on a collision
  always_ff @(posedge clk_b_i)
  begin
    for (int k = 0; k < BE_W; k++)
    begin
      // byte lane write
      if (wr_i.we[k])
      begin
        mem_q[wr_row][8*k +: 8] <= wr_i.wdata[8*k +: 8];
      end
    end
    // output reg only moves on a read
    if (rd_en_i)
    begin
      rd_data_q <= mem_q[rd_row];
    end
  end

  assign rd_data_o = rd_data_q;

endmodule

/* rtl/wmem_pkg.sv */
package wmem_pkg;

  // axi4-lite write side widths
  localparam int unsigned WMEM_ADDR_W = 32;
  localparam int unsigned WMEM_DATA_W = 64;
  localparam int unsigned WMEM_STRB_W = WMEM_DATA_W / 8;

  // one bank is one 16-bit lane, four lanes per group
  localparam int unsigned WMEM_LANE_W = 16;
  localparam int unsigned WMEM_LANES  = WMEM_DATA_W / WMEM_LANE_W;

  // row field, banks only look at the low log2(depth) bits
  localparam int unsigned WMEM_ROW_W = 16;

  // axi write response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } wmem_resp_e;

  // write decoder fsm
  typedef enum logic {
    ST_IDLE,
    ST_RESP
  } wmem_dec_state_e;

  // master to slave, aw + w + b ready
  typedef struct packed {
    logic                   awvalid;
    logic [WMEM_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic [WMEM_DATA_W-1:0] wdata;
    logic [WMEM_STRB_W-1:0] wstrb;
    logic                   bready;
  } wmem_axil_req_t;

  // slave to master
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    wmem_resp_e bresp;
  } wmem_axil_rsp_t;

  // per bank write port, we is one bit per byte
  typedef struct packed {
    logic [WMEM_LANE_W/8-1:0] we;
    logic [WMEM_ROW_W-1:0]    row;
    logic [WMEM_LANE_W-1:0]   wdata;
  } wmem_bank_wr_t;

  // engine read port, addr is a byte address inside the bank
  typedef struct packed {
    logic                   req;
    logic [WMEM_LANE_W-1:0] addr;
  } wmem_rd_req_t;

  typedef struct packed {
    logic                   r_valid;
    logic [WMEM_LANE_W-1:0] rdata;
  } wmem_rd_rsp_t;

endpackage

/* rtl/wmem_read_result.sv */
`timescale 1ns/1ps

module wmem_read_result #(
  parameter int unsigned BANK_DEPTH = 256
) (
  input  logic                     clk_b_i,
  input  logic                     rst_ni,
  input  wmem_pkg::wmem_bank_wr_t  wr_i,
  input  wmem_pkg::wmem_rd_req_t   rd_req_i,
  output wmem_pkg::wmem_rd_rsp_t   rd_rsp_o
);

  localparam int unsigned ROW_W  = wmem_pkg::WMEM_ROW_W;
  localparam int unsigned LANE_W = wmem_pkg::WMEM_LANE_W;

  // depth is a power of two, so the mask makes reads wrap
  localparam logic [ROW_W-1:0] ROW_MASK = ROW_W'(BANK_DEPTH - 1);

  logic              bank_en;
  logic [ROW_W-1:0]  bank_row;
  logic [LANE_W-1:0] bank_data;
  logic              r_valid_q;

  // no grant, every req goes to the bank
  assign bank_en = rd_req_i.req;

  // byte address to 16-bit row
  // bit 0 is the byte inside the lane and is dropped
  assign bank_row = (ROW_W'(rd_req_i.addr) >> 1) & ROW_MASK;

  wmem_bank #(
    .BANK_DEPTH (BANK_DEPTH)
  ) u_bank (
    .clk_b_i   (clk_b_i),
    .wr_i      (wr_i),
    .rd_en_i   (bank_en),
    .rd_row_i  (bank_row),
    .rd_data_o (bank_data)
  );

  // r_valid is req one cycle late, same as the bank latency
  always_ff @(posedge clk_b_i)
  begin
    if (!rst_ni)
    begin
      r_valid_q <= 1'b0;
    end
    else
    begin
      r_valid_q <= rd_req_i.req;
    end
  end

  assign rd_rsp_o.r_valid = r_valid_q;
  // bank output reg holds its value between reads
  assign rd_rsp_o.rdata   = bank_data;

endmodule

/* rtl/wmem_top.sv */
`timescale 1ns/1ps

module wmem_top #(
  parameter int unsigned BANK_DEPTH = 256,
  parameter int unsigned NB_BANKS   = 8
) (
  input  logic                      clk_b_i,
  input  logic                      rst_ni,

  // dma write side
  input  wmem_pkg::wmem_axil_req_t  axil_req_i,
  output wmem_pkg::wmem_axil_rsp_t  axil_rsp_o,

  // engine read side, one port per bank
  input  wmem_pkg::wmem_rd_req_t    rd_req_i [NB_BANKS],
  output wmem_pkg::wmem_rd_rsp_t    rd_rsp_o [NB_BANKS]
);

  // decoder to bank write ports
  wmem_pkg::wmem_bank_wr_t bank_wr [NB_BANKS];

  // aw/w join, range check and lane split
  wmem_axil_decode #(
    .BANK_DEPTH (BANK_DEPTH),
    .NB_BANKS   (NB_BANKS)
  ) u_decode (
    .clk_b_i    (clk_b_i),
    .rst_ni     (rst_ni),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .bank_wr_o  (bank_wr)
  );

  // one bank plus read response stage per lane
  for (genvar i = 0; i < NB_BANKS; i++)
  begin : g_bank
    wmem_read_result #(
      .BANK_DEPTH (BANK_DEPTH)
    ) u_result (
      .clk_b_i  (clk_b_i),
      .rst_ni   (rst_ni),
      .wr_i     (bank_wr[i]),
      .rd_req_i (rd_req_i[i]),
      .rd_rsp_o (rd_rsp_o[i])
    );
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the weight memory testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module wmem_tb \
  -f verilog.f \
  -o wmem_sim

./obj_dir/wmem_sim | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  echo "run.sh: simulation reported success"
else
  echo "run.sh: simulation reported failure"
  exit 1
fi

/* verilog.f */
rtl/wmem_pkg.sv
rtl/wmem_axil_decode.sv
rtl/wmem_bank.sv
rtl/wmem_read_result.sv
rtl/wmem_top.sv
bench/wmem_tb_clock.sv
bench/wmem_asserts.sv
bench/wmem_tb.sv
